// ==== list.f ====
source/cdi_mem_pkg.sv
source/cdi_load_pkg.sv
source/download_unpacker.sv
source/rom_write_fifo.sv
source/sdram_prep_arbiter.sv
source/cdi_loader_top.sv
verif/cdi_loader_chk.sv
verif/cdi_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module cdi_loader_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcdi_loader_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The pass message must appear on a line of its own
if echo "$output" | grep -q "^Test completed successfully$"; then
    exit 0
else
    echo "Pass message not found"
    exit 1
fi

// ==== verif/cdi_loader_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdi_loader_tb;

    localparam int FIFO_DEPTH = 4;
    localparam int ZERO_WORDS = 16;
    localparam int TIMEOUT    = 400;

    // ROM window field and WORM select bit of the memory map
    localparam logic [2:0]  ROM_BASE    = 3'b001;
    localparam logic [15:0] INDEX_ROM   = 16'h0000;
    localparam logic [15:0] INDEX_WORM  = 16'h0040;

    logic        clk_sys;
    logic        cditop_reset;
    logic        ioctl_download;
    logic        ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [15:0] ioctl_dout;
    logic [15:0] ioctl_index;
    logic        sdram_busy;

    logic [24:0] sdram_addr;
    logic [15:0] sdram_din;
    logic        sdram_wr;
    logic        sdram_rd;
    logic        sdram_refresh;
    logic        sdram_word;
    logic        worm_wr;
    logic [12:0] worm_addr;
    logic [7:0]  worm_data;
    logic        zero_done;
    logic        load_overflow;

    // Busy model control and write log
    logic        hold_busy;
    int          seed;
    int          refresh_count;
    logic [24:0] wr_addr_log [$];
    logic [15:0] wr_data_log [$];
    logic        wr_word_log [$];
    logic [15:0] sdram_mem [logic [24:0]];

    cdi_loader_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .ZERO_WORDS (ZERO_WORDS)
    ) cdi_loader_top_i (
        .clk_sys        (clk_sys),
        .cditop_reset   (cditop_reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .sdram_busy     (sdram_busy),
        .sdram_addr     (sdram_addr),
        .sdram_din      (sdram_din),
        .sdram_wr       (sdram_wr),
        .sdram_rd       (sdram_rd),
        .sdram_refresh  (sdram_refresh),
        .sdram_word     (sdram_word),
        .worm_wr        (worm_wr),
        .worm_addr      (worm_addr),
        .worm_data      (worm_data),
        .zero_done      (zero_done),
        .load_overflow  (load_overflow)
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // ====================
    // SDRAM busy model
    // ====================

    // Busy rises the cycle after a command and stays up for 1 to 4 cycles
    initial begin : busy_model
        int busy_left;
        seed       = 32'h512e9248;
        busy_left  = 0;
        sdram_busy = 1'b0;
        forever begin
            @(posedge clk_sys);
            if (cditop_reset) begin
                busy_left = 0;
                sdram_busy <= 1'b0;
            end else if (hold_busy) begin
                sdram_busy <= 1'b1;
            end else if (busy_left > 0) begin
                busy_left = busy_left - 1;
                sdram_busy <= (busy_left > 0);
            end else if (sdram_wr || sdram_rd) begin
                busy_left = 1 + int'($unsigned($random(seed)) % 32'd4);
                sdram_busy <= 1'b1;
            end else begin
                sdram_busy <= 1'b0;
            end
        end
    end

    // Commands last one cycle, so each is seen at exactly one falling edge
    initial begin : command_monitor
        refresh_count = 0;
        forever begin
            @(negedge clk_sys);
            if (!cditop_reset) begin
                if (sdram_wr) begin
                    wr_addr_log.push_back(sdram_addr);
                    wr_data_log.push_back(sdram_din);
                    wr_word_log.push_back(sdram_word);
                    sdram_mem[sdram_addr] = sdram_din;
                end
                if (sdram_rd && sdram_refresh) refresh_count++;
            end
        end
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [24:0] map_rom_addr(input logic [24:0] byte_addr);
        return {ROM_BASE, byte_addr[21:1], 1'b0};
    endfunction

    function automatic logic [15:0] swap_bytes(input logic [15:0] word);
        return {word[7:0], word[15:8]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic wait_writes(input int count, input string what);
        int cycles;
        cycles = 0;
        while (wr_addr_log.size() < count && cycles < TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (wr_addr_log.size() < count) timeout_fail(what);
    endtask

    task automatic wait_zero_done(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (zero_done !== level && cycles < TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (zero_done !== level) timeout_fail(what);
    endtask

    task automatic wait_refresh(input int base, input string what);
        int cycles;
        cycles = 0;
        while (refresh_count <= base && cycles < TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (refresh_count <= base) timeout_fail(what);
    endtask

    task automatic wait_busy_high(input string what);
        int cycles;
        cycles = 0;
        while (sdram_busy !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (sdram_busy !== 1'b1) timeout_fail(what);
    endtask

    task automatic wait_overflow(input string what);
        int cycles;
        cycles = 0;
        while (load_overflow !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (load_overflow !== 1'b1) timeout_fail(what);
    endtask

    // One download strobe, held for a single cycle
    task automatic send_word(input logic [24:0] addr, input logic [15:0] data,
                             input logic [15:0] index);
        @(posedge clk_sys);
        ioctl_wr    <= 1'b1;
        ioctl_addr  <= addr;
        ioctl_dout  <= data;
        ioctl_index <= index;
        @(posedge clk_sys);
        ioctl_wr    <= 1'b0;
    endtask

    // ====================
    // Directed tests
    // ====================

    task automatic test_idle();
        int i;
        check_value("zero_done", 32'(zero_done), 32'd1);
        check_value("load_overflow", 32'(load_overflow), 32'd0);
        for (i = 0; i < 20; i++) begin
            @(negedge clk_sys);
            check_value("sdram_wr", 32'(sdram_wr), 32'd0);
            check_value("sdram_rd", 32'(sdram_rd), 32'd0);
            check_value("worm_wr", 32'(worm_wr), 32'd0);
        end
    endtask

    task automatic test_zero_sweep();
        int base_wr;
        int i;
        base_wr = wr_addr_log.size();
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        wait_zero_done(1'b0, "the zeroing sweep to start");
        wait_zero_done(1'b1, "the zeroing sweep to finish");
        check_value("zero write count", 32'(wr_addr_log.size() - base_wr), 32'(ZERO_WORDS));
        for (i = 0; i < ZERO_WORDS; i++) begin
            check_value("sdram_addr", 32'(wr_addr_log[base_wr + i]), 32'(2 * i));
            check_value("sdram_din", 32'(wr_data_log[base_wr + i]), 32'd0);
            check_value("sdram_word", 32'(wr_word_log[base_wr + i]), 32'd1);
        end
        // Download still high with nothing queued
        wait_refresh(refresh_count, "a refresh read after the sweep");
    endtask

    task automatic test_rom_words();
        logic [24:0] addrs [4];
        logic [15:0] datas [4];
        int          base_wr;
        int          i;
        addrs   = '{25'h0123456, 25'h0200010, 25'h1C00ABC, 25'h03FFFFE};
        datas   = '{16'h1234, 16'hBEEF, 16'h00FF, 16'hA55A};
        base_wr = wr_addr_log.size();
        for (i = 0; i < 4; i++) begin
            send_word(addrs[i], datas[i], INDEX_ROM);
            repeat (5) @(posedge clk_sys);
        end
        wait_writes(base_wr + 4, "the ROM word writes");
        for (i = 0; i < 4; i++) begin
            check_value("sdram_addr", 32'(wr_addr_log[base_wr + i]),
                        32'(map_rom_addr(addrs[i])));
            check_value("sdram_din", 32'(wr_data_log[base_wr + i]),
                        32'(swap_bytes(datas[i])));
            check_value("sdram_word", 32'(wr_word_log[base_wr + i]), 32'd1);
        end
        // A refresh read means the queue has drained
        wait_refresh(refresh_count, "a refresh read after the ROM words");
        check_value("ROM write count", 32'(wr_addr_log.size() - base_wr), 32'd4);
    endtask

    task automatic test_worm_word();
        logic [24:0] addr;
        logic [15:0] data;
        int          base_wr;
        addr    = 25'h0153A46;
        data    = 16'hC35A;
        base_wr = wr_addr_log.size();
        send_word(addr, data, INDEX_WORM);
        @(negedge clk_sys);
        check_value("worm_wr", 32'(worm_wr), 32'd1);
        check_value("worm_addr", 32'(worm_addr), 32'(addr[12:0]));
        check_value("worm_data", 32'(worm_data), 32'(data[7:0]));
        @(negedge clk_sys);
        check_value("worm_wr", 32'(worm_wr), 32'd1);
        check_value("worm_addr", 32'(worm_addr), 32'({addr[12:1], 1'b1}));
        check_value("worm_data", 32'(worm_data), 32'(data[15:8]));
        @(negedge clk_sys);
        check_value("worm_wr", 32'(worm_wr), 32'd0);
        repeat (10) @(negedge clk_sys);
        check_value("SDRAM write count", 32'(wr_addr_log.size() - base_wr), 32'd0);
    endtask

    task automatic test_overflow();
        logic [24:0] addr;
        int          base_wr;
        int          i;
        base_wr = wr_addr_log.size();
        @(posedge clk_sys);
        hold_busy <= 1'b1;
        wait_busy_high("sdram_busy to be held");
        // One strobe per cycle, one more than the queue holds
        for (i = 0; i <= FIFO_DEPTH; i++) begin
            @(posedge clk_sys);
            ioctl_wr    <= 1'b1;
            ioctl_addr  <= 25'h0004000 + 25'(2 * i);
            ioctl_dout  <= 16'hA500 + 16'(i);
            ioctl_index <= INDEX_ROM;
        end
        @(posedge clk_sys);
        ioctl_wr <= 1'b0;
        wait_overflow("load_overflow to rise");
        repeat (4) @(negedge clk_sys);
        check_value("SDRAM write count", 32'(wr_addr_log.size() - base_wr), 32'd0);
        @(posedge clk_sys);
        hold_busy <= 1'b0;
        wait_writes(base_wr + FIFO_DEPTH, "the queued ROM writes");
        wait_refresh(refresh_count, "a refresh read after the queued writes");
        check_value("ROM write count", 32'(wr_addr_log.size() - base_wr), 32'(FIFO_DEPTH));
        for (i = 0; i < FIFO_DEPTH; i++) begin
            addr = 25'h0004000 + 25'(2 * i);
            check_value("sdram_addr", 32'(wr_addr_log[base_wr + i]), 32'(map_rom_addr(addr)));
            check_value("sdram_din", 32'(wr_data_log[base_wr + i]),
                        32'(swap_bytes(16'hA500 + 16'(i))));
        end
        addr = 25'h0004000 + 25'(2 * FIFO_DEPTH);
        check_value("dropped word written", 32'(sdram_mem.exists(map_rom_addr(addr))), 32'd0);
        check_value("load_overflow", 32'(load_overflow), 32'd1);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        hold_busy      = 1'b0;
        cditop_reset   = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ioctl_index    = '0;

        repeat (10) @(posedge clk_sys);
        cditop_reset <= 1'b0;
        @(negedge clk_sys);

        test_idle();
        test_zero_sweep();
        test_rom_words();
        test_worm_word();
        test_overflow();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/cdi_loader_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdi_loader_chk (
    input wire clk_sys,
    input wire cditop_reset,
    input wire sdram_busy,
    input wire sdram_wr,
    input wire sdram_rd,
    input wire sdram_refresh
);

    // Write and read are separate commands
    wr_rd_exclusive: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        !(sdram_wr && sdram_rd)
    ) else $error("sdram_wr and sdram_rd are high together");

    // The controller accepts commands only while idle
    no_cmd_when_busy: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        (sdram_wr || sdram_rd) |-> !sdram_busy
    ) else $error("SDRAM command issued while sdram_busy is high");

    // Refresh is a flavour of read
    refresh_with_rd: assert property (
        @(posedge clk_sys) disable iff (cditop_reset)
        sdram_refresh |-> sdram_rd
    ) else $error("sdram_refresh is high without sdram_rd");

endmodule

bind sdram_prep_arbiter cdi_loader_chk chk_i (
    .clk_sys       (clk_sys),
    .cditop_reset  (cditop_reset),
    .sdram_busy    (sdram_busy),
    .sdram_wr      (sdram_wr),
    .sdram_rd      (sdram_rd),
    .sdram_refresh (sdram_refresh)
);

`default_nettype wire

// ==== source/cdi_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdi_loader_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int ZERO_WORDS = 16
) (
    input  wire                        clk_sys,
    input  wire                        cditop_reset,

    // Download stream
    input  wire                        ioctl_download,
    input  wire                        ioctl_wr,
    input  cdi_load_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_load_pkg::ioctl_data_t  ioctl_dout,
    input  cdi_load_pkg::ioctl_index_t ioctl_index,

    // SDRAM command port
    input  wire                        sdram_busy,
    output cdi_mem_pkg::sdram_addr_t   sdram_addr,
    output cdi_mem_pkg::sdram_data_t   sdram_din,
    output logic                       sdram_wr,
    output logic                       sdram_rd,
    output logic                       sdram_refresh,
    output logic                       sdram_word,

    // Slave WORM
    output logic                       worm_wr,
    output cdi_load_pkg::worm_addr_t   worm_addr,
    output cdi_load_pkg::worm_data_t   worm_data,

    output logic                       zero_done,
    output logic                       load_overflow
);

    import cdi_mem_pkg::*;

    logic                  push;
    logic [ROM_WORD_W-1:0] push_addr;
    sdram_data_t           push_data;
    logic                  pop;
    logic                  not_empty;
    logic [ROM_WORD_W-1:0] head_addr;
    sdram_data_t           head_data;

    download_unpacker unpacker_i (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .ioctl_wr     (ioctl_wr),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .ioctl_index  (ioctl_index),
        .push         (push),
        .push_addr    (push_addr),
        .push_data    (push_data),
        .worm_wr      (worm_wr),
        .worm_addr    (worm_addr),
        .worm_data    (worm_data)
    );

    rom_write_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk_sys       (clk_sys),
        .cditop_reset  (cditop_reset),
        .push          (push),
        .push_addr     (push_addr),
        .push_data     (push_data),
        .pop           (pop),
        .not_empty     (not_empty),
        .head_addr     (head_addr),
        .head_data     (head_data),
        .load_overflow (load_overflow)
    );

    sdram_prep_arbiter #(
        .ZERO_WORDS (ZERO_WORDS)
    ) arbiter_i (
        .clk_sys        (clk_sys),
        .cditop_reset   (cditop_reset),
        .ioctl_download (ioctl_download),
        .not_empty      (not_empty),
        .head_addr      (head_addr),
        .head_data      (head_data),
        .sdram_busy     (sdram_busy),
        .pop            (pop),
        .zero_done      (zero_done),
        .sdram_addr     (sdram_addr),
        .sdram_din      (sdram_din),
        .sdram_wr       (sdram_wr),
        .sdram_rd       (sdram_rd),
        .sdram_refresh  (sdram_refresh),
        .sdram_word     (sdram_word)
    );

endmodule

`default_nettype wire

// ==== source/sdram_prep_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_prep_arbiter #(
    parameter int ZERO_WORDS = 16
) (
    input  wire                               clk_sys,
    input  wire                               cditop_reset,
    input  wire                               ioctl_download,

    input  wire                               not_empty,
    input  wire [cdi_mem_pkg::ROM_WORD_W-1:0] head_addr,
    input  cdi_mem_pkg::sdram_data_t          head_data,

    input  wire                               sdram_busy,

    output logic                              pop,
    output logic                              zero_done,

    output cdi_mem_pkg::sdram_addr_t          sdram_addr,
    output cdi_mem_pkg::sdram_data_t          sdram_din,
    output logic                              sdram_wr,
    output logic                              sdram_rd,
    output logic                              sdram_refresh,
    output logic                              sdram_word
);

    import cdi_mem_pkg::*;

    localparam int ZC_W = $clog2(ZERO_WORDS + 1);

    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;

    logic            sdram_busy_q;
    logic            download_q;
    logic            download_rise;
    logic            prepare;
    logic            cmd_ok;
    logic            done_edge;
    logic            zero_complete;
    logic [ZC_W-1:0] zero_cnt;

    // ====================
    // Status decode
    // ====================

    assign download_rise = ioctl_download && !download_q;
    assign zero_done     = (zero_cnt == ZC_W'(ZERO_WORDS));
    assign prepare       = ioctl_download || !zero_done;

    // Busy falling ends the command in flight
    assign done_edge     = sdram_busy_q && !sdram_busy;
    assign pop           = done_edge && (owner_q == ROM_DOWNLOAD);
    assign zero_complete = done_edge && (owner_q == RAM_ZERO);

    // No new command in the cycle where busy falls, the FIFO head
    // and the zero address are still being updated then
    assign cmd_ok = !sdram_busy && !sdram_busy_q;

    // ====================
    // Owner selection
    // ====================

    always_comb begin
        owner_next = IDLE;

        if (prepare) begin
            owner_next = REFRESH;
            if (!zero_done) owner_next = RAM_ZERO;
            if (not_empty) owner_next = ROM_DOWNLOAD;
        end

        // Hold the owner for the whole command
        if (sdram_busy) owner = owner_q;
        else owner = owner_next;
    end

    // ====================
    // Command fields
    // ====================

    always_comb begin
        sdram_addr    = sdram_addr_t'({zero_cnt, 1'b0});
        sdram_din     = '0;
        sdram_wr      = 1'b0;
        sdram_rd      = 1'b0;
        sdram_refresh = 1'b0;
        sdram_word    = 1'b0;

        case (owner)
            ROM_DOWNLOAD: begin
                sdram_addr = {ROM_WINDOW_BASE, head_addr, 1'b0};
                sdram_din  = head_data;
                sdram_wr   = cmd_ok;
                sdram_word = 1'b1;
            end
            RAM_ZERO: begin
                sdram_wr   = cmd_ok;
                sdram_word = 1'b1;
            end
            REFRESH: begin
                sdram_rd      = cmd_ok;
                sdram_refresh = cmd_ok;
                sdram_word    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q      <= IDLE;
            sdram_busy_q <= 1'b0;
            download_q   <= 1'b0;
            // Start with the sweep finished
            zero_cnt     <= ZC_W'(ZERO_WORDS);
        end else begin
            owner_q      <= owner;
            sdram_busy_q <= sdram_busy;
            download_q   <= ioctl_download;

            // New download restarts the sweep at address 0
            if (download_rise) zero_cnt <= '0;
            else if (zero_complete) zero_cnt <= zero_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/rom_write_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_write_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                               clk_sys,
    input  wire                               cditop_reset,

    input  wire                               push,
    input  wire [cdi_mem_pkg::ROM_WORD_W-1:0] push_addr,
    input  cdi_mem_pkg::sdram_data_t          push_data,
    input  wire                               pop,

    output logic                              not_empty,
    output logic [cdi_mem_pkg::ROM_WORD_W-1:0] head_addr,
    output cdi_mem_pkg::sdram_data_t          head_data,
    output logic                              load_overflow
);

    import cdi_mem_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [ROM_WORD_W-1:0] addr_mem [FIFO_DEPTH];
    sdram_data_t           data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // Wrap at the configured depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign wr_en     = push && !full;
    assign rd_en     = pop && not_empty;

    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            load_overflow <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Sticky until reset, the dropped word is lost
            if (push && full) load_overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/download_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module download_unpacker (
    input  wire                               clk_sys,
    input  wire                               cditop_reset,

    input  wire                               ioctl_wr,
    input  cdi_load_pkg::ioctl_addr_t         ioctl_addr,
    input  cdi_load_pkg::ioctl_data_t         ioctl_dout,
    input  cdi_load_pkg::ioctl_index_t        ioctl_index,

    output logic                              push,
    output logic [cdi_mem_pkg::ROM_WORD_W-1:0] push_addr,
    output cdi_mem_pkg::sdram_data_t          push_data,

    output logic                              worm_wr,
    output cdi_load_pkg::worm_addr_t          worm_addr,
    output cdi_load_pkg::worm_data_t          worm_data
);

    import cdi_mem_pkg::*;
    import cdi_load_pkg::*;

    logic       rom_strobe;
    logic       worm_strobe;
    logic       worm_strobe_q;
    worm_data_t worm_high;

    // Index decode
    assign worm_strobe = ioctl_wr && ioctl_index[WORM_INDEX_BIT];
    assign rom_strobe  = ioctl_wr && !ioctl_index[WORM_INDEX_BIT];

    // ====================
    // Strobes
    // ====================

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            push          <= 1'b0;
            worm_strobe_q <= 1'b0;
            worm_wr       <= 1'b0;
        end else begin
            push          <= rom_strobe;
            worm_strobe_q <= worm_strobe;
            // Two byte writes, one per cycle
            worm_wr       <= worm_strobe || worm_strobe_q;
        end
    end

    // ====================
    // Payload
    // ====================

    // ROM word goes out byte swapped, low byte in the upper half
    always_ff @(posedge clk_sys) begin
        if (rom_strobe) begin
            push_addr <= ioctl_addr[ROM_WORD_W:1];
            push_data <= {ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (worm_strobe) begin
            // Lower byte first
            worm_addr <= ioctl_addr[WORM_ADDR_W-1:0];
            worm_data <= ioctl_dout[WORM_DATA_W-1:0];
            worm_high <= ioctl_dout[IOCTL_DATA_W-1:WORM_DATA_W];
        end else begin
            // Upper byte on the following cycle, odd address
            worm_data    <= worm_high;
            worm_addr[0] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/cdi_load_pkg.sv ====
`default_nettype none

package cdi_load_pkg;

    // Download stream from the HPS side
    localparam int IOCTL_ADDR_W  = 25;
    localparam int IOCTL_DATA_W  = 16;
    localparam int IOCTL_INDEX_W = 16;

    typedef logic [IOCTL_ADDR_W-1:0]  ioctl_addr_t;
    typedef logic [IOCTL_DATA_W-1:0]  ioctl_data_t;
    typedef logic [IOCTL_INDEX_W-1:0] ioctl_index_t;

    // Index bit set for the slave WORM image, clear for the main ROM
    localparam int WORM_INDEX_BIT = 6;

    // Slave write-once memory, byte wide
    localparam int WORM_ADDR_W = 13;
    localparam int WORM_DATA_W = 8;

    typedef logic [WORM_ADDR_W-1:0] worm_addr_t;
    typedef logic [WORM_DATA_W-1:0] worm_data_t;

endpackage

`default_nettype wire

// ==== source/cdi_mem_pkg.sv ====
`default_nettype none

package cdi_mem_pkg;

    // ====================
    // SDRAM memory map
    // ====================

    localparam int SDRAM_ADDR_W = 25;
    localparam int SDRAM_DATA_W = 16;

    // Word address carried from the download stream into the ROM window
    localparam int ROM_WORD_W = 21;

    typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;
    typedef logic [SDRAM_DATA_W-1:0] sdram_data_t;

    // Top address field that selects the main ROM window
    localparam logic [2:0] ROM_WINDOW_BASE = 3'b001;

    // Command port owners, highest priority first
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        RAM_ZERO,
        REFRESH,
        IDLE
    } sdram_owner_e;

endpackage

`default_nettype wire
